//--- project.f
verilog/hci_split_pkg.sv
verilog/hci_fifo_buf.sv
verilog/hci_chan_fifo.sv
verilog/hci_core_split.sv
verilog/hci_tcdm_bank.sv
verilog/hci_split_top.sv
tests/tb_hci_split.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the split testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -sv --top-module tb_hci_split -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_hci_split)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

//--- tests/tb_hci_split.sv
//==========================================================================
// Testbench for the wide-to-narrow TCDM split. A table of operations is
// applied in order, a wide-word reference model predicts every response,
// and random per-bank stalls plus lrdy holds exercise back-pressure.
//==========================================================================
`timescale 1ns/1ps

module tb_hci_split;

  import hci_split_pkg::*;

  localparam int unsigned WIDE_DW   = WIDE_DW_DEF;
  localparam int unsigned NB_CHAN   = NB_CHAN_DEF;
  localparam int          N_OPS     = 60;
  localparam int          TIMEOUT   = 40 * N_OPS + 200;
  localparam int          REF_WORDS = 32;  // wide words used, addresses below 0x100

  typedef struct packed {
    bit                 rd;     // 1 = read
    logic [ADDR_W-1:0]  add;
    logic [WIDE_DW-1:0] data;
    logic [7:0]         be;
    int                 hold;   // cycles lrdy_i stays low on this response
    bit                 stall;  // random bank stalls while issuing
  } op_t;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 req_i, wen_i, lrdy_i, gnt_o, r_valid_o;
  logic [ADDR_W-1:0]    add_i;
  logic [WIDE_DW/8-1:0] be_i;
  logic [WIDE_DW-1:0]   data_i, r_data_o;
  logic [NB_CHAN-1:0]   stall_i;

  op_t                ops [N_OPS];
  int                 n_ops;
  logic [WIDE_DW-1:0] ref_mem [REF_WORDS];
  logic [WIDE_DW-1:0] exp_q[$];   // expected responses, request order
  int                 hold_q[$];
  bit                 stall_en;
  int                 errors, checks, granted, responses, blocked_cnt, cycles;

  hci_split_top dut (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .req_i     ( req_i     ),
    .add_i     ( add_i     ),
    .wen_i     ( wen_i     ),
    .be_i      ( be_i      ),
    .data_i    ( data_i    ),
    .lrdy_i    ( lrdy_i    ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o ),
    .r_data_o  ( r_data_o  ),
    .stall_i   ( stall_i   )
  );

  always #2 clk_i = ~clk_i;  // 4 ns period

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, %0d responses still missing", cycles, exp_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_op(input bit rd, input logic [ADDR_W-1:0] add,
                        input logic [WIDE_DW-1:0] data, input logic [7:0] be,
                        input int hold, input bit stall);
    ops[n_ops] = '{rd: rd, add: add, data: data, be: be, hold: hold, stall: stall};
    n_ops++;
  endtask

  function automatic logic [WIDE_DW-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a ^ 32'hc3a5_0f96, a * 32'h9e37_79b9};
  endfunction

  task automatic build_table();
    logic [ADDR_W-1:0] a;
    // full-word writes, then reads back
    for (int k = 0; k < 8; k++) add_op(1'b0, 32'(k * 8), fill_word(32'(k * 8)), 8'hff, 0, 1'b0);
    for (int k = 0; k < 8; k++) add_op(1'b1, 32'(k * 8), '0, 8'h00, 0, 1'b0);
    // partial writes, some spanning both channels
    add_op(1'b0, 32'h08, 64'h1122_3344_5566_7788, 8'h3c, 0, 1'b0);
    add_op(1'b0, 32'h10, 64'ha1b2_c3d4_e5f6_0718, 8'h81, 0, 1'b0);
    add_op(1'b0, 32'h18, 64'hdead_beef_cafe_f00d, 8'h18, 0, 1'b0);
    add_op(1'b0, 32'h20, 64'h0bad_f00d_1234_5678, 8'hf0, 0, 1'b0);
    for (int k = 1; k < 5; k++) add_op(1'b1, 32'(k * 8), '0, 8'h00, 0, 1'b0);
    // random mix under bank stalls
    for (int k = 0; k < 24; k++) begin
      a = 32'(($urandom % 8) * 8);
      add_op(($urandom % 2) == 0, a, {$urandom, $urandom}, 8'($urandom),
             int'($urandom % 3), 1'b1);
    end
    // back to back, lrdy low long enough to fill every FIFO
    add_op(1'b1, 32'h00, '0, 8'h00, 14, 1'b0);
    for (int k = 0; k < 11; k++) begin
      add_op(k % 2 == 1, 32'(8 * (5 + k % 3)), fill_word(32'(k + 100)), 8'hff, 0, 1'b0);
    end
  endtask

  // model update at grant time, in request order
  task automatic apply_to_model(input op_t op);
    int idx;
    idx = int'(op.add[7:3]);
    granted++;
    if (op.rd) begin
      exp_q.push_back(ref_mem[idx]);
    end else begin
      for (int b = 0; b < WIDE_DW / 8; b++) begin
        if (op.be[b]) ref_mem[idx][b*8 +: 8] = op.data[b*8 +: 8];
      end
      exp_q.push_back('0);  // writes answer with zero
    end
    hold_q.push_back(op.hold);
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    for (int b = 0; b < NB_CHAN; b++) begin
      stall_i[b] = stall_en && (($urandom % 4) == 0);  // about one in four
    end
  endtask

  initial begin : drive_requests
    void'($urandom(32'hb826ee20));
    rst_ni   = 1'b0;
    req_i    = 1'b0;
    add_i    = '0;
    wen_i    = 1'b1;
    be_i     = '0;
    data_i   = '0;
    stall_i  = '0;
    stall_en = 1'b0;
    build_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_value(64'(gnt_o), 64'd0, "gnt_o in reset");
    check_value(64'(r_valid_o), 64'd0, "r_valid_o in reset");
    rst_ni = 1'b1;
    #1;
    check_value(64'(gnt_o), 64'd0, "gnt_o after reset");
    check_value(64'(r_valid_o), 64'd0, "r_valid_o after reset");
    for (int i = 0; i < n_ops; i++) begin
      stall_en = ops[i].stall;
      next_cycle();
      req_i  = 1'b1;
      wen_i  = ops[i].rd;
      add_i  = ops[i].add;
      be_i   = ops[i].be;
      data_i = ops[i].data;
      #1;
      while (!gnt_o) begin
        if (!stall_en) blocked_cnt++;  // only full FIFOs block here
        next_cycle();
        #1;
      end
      apply_to_model(ops[i]);
    end
    stall_en = 1'b0;
    next_cycle();
    req_i = 1'b0;
    while (exp_q.size() != 0) next_cycle();
    repeat (2) next_cycle();
    #1;
    check_value(64'(r_valid_o), 64'd0, "r_valid_o when idle");
    check_value(64'(gnt_o), 64'd0, "gnt_o when idle");
    check_value(64'(responses), 64'(granted), "responses against grants");
    if (blocked_cnt == 0) begin
      errors++;
      $display("gnt_o never went low while the FIFOs were full");
    end
    $display("checks %0d, errors %0d, grants %0d, responses %0d",
             checks, errors, granted, responses);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : collect_responses
    int                 waited;
    bit                 held;
    logic [WIDE_DW-1:0] held_data;
    logic [WIDE_DW-1:0] exp;
    lrdy_i = 1'b1;
    waited = 0;
    held   = 1'b0;
    forever begin
      @(negedge clk_i);
      lrdy_i = 1'b1;
      if (exp_q.size() > 0) begin
        if (waited < hold_q[0]) lrdy_i = 1'b0;
      end
      #1;
      if (held) begin
        check_value(64'(r_valid_o), 64'd1, "r_valid_o dropped while lrdy_i low");
        check_value(r_data_o, held_data, "r_data_o changed while lrdy_i low");
      end
      held = 1'b0;
      if (r_valid_o && !lrdy_i) begin
        waited++;
        held      = 1'b1;
        held_data = r_data_o;
      end else if (r_valid_o && lrdy_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected response at %0t with nothing outstanding", $time);
        end else begin
          exp = exp_q.pop_front();
          void'(hold_q.pop_front());
          check_value(r_data_o, exp, $sformatf("response %0d data", responses));
        end
        responses++;
        waited = 0;
      end
    end
  end

endmodule

//--- verilog/hci_split_top.sv
//==========================================================================
// Top level of the split: one wide TCDM port in, NB_CHAN banks behind
// per-channel request and response FIFOs. stall_i throttles each bank
// separately so back-pressure can be driven from outside.
//==========================================================================
`timescale 1ns/1ps

module hci_split_top #(
  parameter int unsigned WIDE_DW    = hci_split_pkg::WIDE_DW_DEF,
  parameter int unsigned NB_CHAN    = hci_split_pkg::NB_CHAN_DEF,
  parameter int unsigned FIFO_DEPTH = hci_split_pkg::FIFO_DEPTH_DEF,
  parameter int unsigned BANK_WORDS = hci_split_pkg::BANK_WORDS_DEF
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic [hci_split_pkg::ADDR_W-1:0] add_i,
  input  logic                             wen_i,
  input  logic [WIDE_DW/8-1:0]             be_i,
  input  logic [WIDE_DW-1:0]               data_i,
  input  logic                             lrdy_i,
  output logic                             gnt_o,
  output logic                             r_valid_o,
  output logic [WIDE_DW-1:0]               r_data_o,
  input  logic [NB_CHAN-1:0]               stall_i
);

  import hci_split_pkg::*;

  localparam int unsigned NDW = WIDE_DW/NB_CHAN;
  localparam int unsigned NBW = NDW/8;

  // split to channel FIFOs
  logic [NB_CHAN-1:0]             ch_req, ch_wen, ch_pop, ch_gnt, ch_r_valid;
  logic [NB_CHAN-1:0][ADDR_W-1:0] ch_add;
  logic [NB_CHAN-1:0][NBW-1:0]    ch_be;
  logic [NB_CHAN-1:0][NDW-1:0]    ch_data, ch_r_data;
  // channel FIFOs to banks
  logic [NB_CHAN-1:0]             bank_req, bank_wen, bank_gnt, bank_r_valid;
  logic [NB_CHAN-1:0][ADDR_W-1:0] bank_add;
  logic [NB_CHAN-1:0][NBW-1:0]    bank_be;
  logic [NB_CHAN-1:0][NDW-1:0]    bank_data, bank_r_data;

  hci_core_split #(
    .WIDE_DW ( WIDE_DW ),
    .NB_CHAN ( NB_CHAN )
  ) i_split (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .add_i        ( add_i      ),
    .wen_i        ( wen_i      ),
    .be_i         ( be_i       ),
    .data_i       ( data_i     ),
    .lrdy_i       ( lrdy_i     ),
    .gnt_o        ( gnt_o      ),
    .r_valid_o    ( r_valid_o  ),
    .r_data_o     ( r_data_o   ),
    .ch_req_o     ( ch_req     ),
    .ch_add_o     ( ch_add     ),
    .ch_wen_o     ( ch_wen     ),
    .ch_be_o      ( ch_be      ),
    .ch_data_o    ( ch_data    ),
    .ch_pop_o     ( ch_pop     ),
    .ch_gnt_i     ( ch_gnt     ),
    .ch_r_valid_i ( ch_r_valid ),
    .ch_r_data_i  ( ch_r_data  )
  );

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    hci_chan_fifo #(
      .DW         ( NDW        ),
      .FIFO_DEPTH ( FIFO_DEPTH )
    ) i_chan_fifo (
      .clk_i          ( clk_i            ),
      .rst_ni         ( rst_ni           ),
      .req_i          ( ch_req[ii]       ),
      .add_i          ( ch_add[ii]       ),
      .wen_i          ( ch_wen[ii]       ),
      .be_i           ( ch_be[ii]        ),
      .data_i         ( ch_data[ii]      ),
      .gnt_o          ( ch_gnt[ii]       ),
      .r_valid_o      ( ch_r_valid[ii]   ),
      .r_data_o       ( ch_r_data[ii]    ),
      .pop_i          ( ch_pop[ii]       ),
      .bank_req_o     ( bank_req[ii]     ),
      .bank_add_o     ( bank_add[ii]     ),
      .bank_wen_o     ( bank_wen[ii]     ),
      .bank_be_o      ( bank_be[ii]      ),
      .bank_data_o    ( bank_data[ii]    ),
      .bank_gnt_i     ( bank_gnt[ii]     ),
      .bank_r_valid_i ( bank_r_valid[ii] ),
      .bank_r_data_i  ( bank_r_data[ii]  )
    );

    hci_tcdm_bank #(
      .DW         ( NDW        ),
      .BANK_WORDS ( BANK_WORDS )
    ) i_bank (
      .clk_i     ( clk_i            ),
      .rst_ni    ( rst_ni           ),
      .req_i     ( bank_req[ii]     ),
      .add_i     ( bank_add[ii]     ),
      .wen_i     ( bank_wen[ii]     ),
      .be_i      ( bank_be[ii]      ),
      .data_i    ( bank_data[ii]    ),
      .stall_i   ( stall_i[ii]      ),
      .gnt_o     ( bank_gnt[ii]     ),
      .r_valid_o ( bank_r_valid[ii] ),
      .r_data_o  ( bank_r_data[ii]  )
    );
  end

endmodule

//--- verilog/hci_tcdm_bank.sv
//==========================================================================
// Simple single-port TCDM bank model with byte enables.
// stall_i holds back the grant. Every granted request, read or write,
// answers exactly one cycle later. Writes answer with zero data.
//==========================================================================
`timescale 1ns/1ps

module hci_tcdm_bank #(
  parameter int unsigned DW         = 32,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic [hci_split_pkg::ADDR_W-1:0] add_i,
  input  logic                             wen_i,   // high = read
  input  logic [DW/8-1:0]                  be_i,
  input  logic [DW-1:0]                    data_i,
  input  logic                             stall_i,
  output logic                             gnt_o,
  output logic                             r_valid_o,
  output logic [DW-1:0]                    r_data_o
);

  import hci_split_pkg::*;

  localparam int unsigned BW    = DW/8;
  localparam int unsigned IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  logic [DW-1:0]     mem_q [BANK_WORDS];
  logic [IDX_W-1:0]  idx;
  logic [ADDR_W-1:0] word_add;
  logic              r_valid_q;
  logic [DW-1:0]     r_data_q;

  assign word_add = add_i / BW;
  assign idx      = IDX_W'(word_add % BANK_WORDS);
  assign gnt_o    = req_i & ~stall_i;

  // memory and read data, no reset on payload
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (wen_i) begin
        r_data_q <= mem_q[idx];
      end else begin
        r_data_q <= '0;
        for (int b = 0; b < BW; b++) begin
          if (be_i[b]) mem_q[idx][b*8 +: 8] <= data_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= gnt_o;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule

//--- verilog/hci_core_split.sv
//==========================================================================
// Wide-to-narrow split of one TCDM port into NB_CHAN channels.
// Each channel gets its slice of data and byte enables at an address
// offset of one narrow word per channel. The wide grant waits for all
// channels, with early channels masked. Responses are joined back from
// the channel response FIFO heads.
//==========================================================================
`timescale 1ns/1ps

module hci_core_split #(
  parameter int unsigned WIDE_DW = 64,
  parameter int unsigned NB_CHAN = 2
) (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // wide side
  input  logic                                             req_i,
  input  logic [hci_split_pkg::ADDR_W-1:0]                 add_i,
  input  logic                                             wen_i,   // high = read
  input  logic [WIDE_DW/8-1:0]                             be_i,
  input  logic [WIDE_DW-1:0]                               data_i,
  input  logic                                             lrdy_i,
  output logic                                             gnt_o,
  output logic                                             r_valid_o,
  output logic [WIDE_DW-1:0]                               r_data_o,
  // channel side
  output logic [NB_CHAN-1:0]                               ch_req_o,
  output logic [NB_CHAN-1:0][hci_split_pkg::ADDR_W-1:0]    ch_add_o,
  output logic [NB_CHAN-1:0]                               ch_wen_o,
  output logic [NB_CHAN-1:0][WIDE_DW/NB_CHAN/8-1:0]        ch_be_o,
  output logic [NB_CHAN-1:0][WIDE_DW/NB_CHAN-1:0]          ch_data_o,
  output logic [NB_CHAN-1:0]                               ch_pop_o,
  input  logic [NB_CHAN-1:0]                               ch_gnt_i,
  input  logic [NB_CHAN-1:0]                               ch_r_valid_i,
  input  logic [NB_CHAN-1:0][WIDE_DW/NB_CHAN-1:0]          ch_r_data_i
);

  import hci_split_pkg::*;

  localparam int unsigned NDW = WIDE_DW/NB_CHAN;  // narrow data width
  localparam int unsigned NBW = NDW/8;            // bytes per narrow word

  logic [NB_CHAN-1:0] mask_d, mask_q;  // channels already granted
  logic [NB_CHAN-1:0] ch_done;
  logic               rsp_fire;

  // request slicing
  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_slice
    assign ch_add_o[ii]  = add_i + ADDR_W'(ii*NBW);
    assign ch_wen_o[ii]  = wen_i;
    assign ch_be_o[ii]   = be_i[ii*NBW +: NBW];
    assign ch_data_o[ii] = data_i[ii*NDW +: NDW];
  end

  // masked channels must not push a second copy
  assign ch_req_o = {NB_CHAN{req_i}} & ~mask_q;
  assign ch_done  = (ch_req_o & ch_gnt_i) | mask_q;
  assign gnt_o    = req_i & (&ch_done);

  // mask grows while the wide grant is pending, clears when it fires
  assign mask_d = gnt_o ? '0 : (mask_q | (ch_req_o & ch_gnt_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
    end else begin
      mask_q <= mask_d;
    end
  end

  // response join, channel 0 in the low bits
  assign r_valid_o = &ch_r_valid_i;
  assign r_data_o  = ch_r_data_i;
  assign rsp_fire  = r_valid_o & lrdy_i;
  assign ch_pop_o  = {NB_CHAN{rsp_fire}};  // all heads leave together

endmodule

//--- verilog/hci_chan_fifo.sv
//==========================================================================
// Per-channel decoupling between the split and one bank.
// A request FIFO feeds the bank with no added cycle and a response FIFO
// collects its answers. Bank issue is limited so that every outstanding
// request is sure to find a free response slot.
//==========================================================================
`timescale 1ns/1ps

module hci_chan_fifo #(
  parameter int unsigned DW         = 32,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // narrow request from the split
  input  logic                           req_i,
  input  logic [hci_split_pkg::ADDR_W-1:0] add_i,
  input  logic                           wen_i,
  input  logic [DW/8-1:0]                be_i,
  input  logic [DW-1:0]                  data_i,
  output logic                           gnt_o,
  // narrow response to the split
  output logic                           r_valid_o,
  output logic [DW-1:0]                  r_data_o,
  input  logic                           pop_i,
  // bank side
  output logic                           bank_req_o,
  output logic [hci_split_pkg::ADDR_W-1:0] bank_add_o,
  output logic                           bank_wen_o,
  output logic [DW/8-1:0]                bank_be_o,
  output logic [DW-1:0]                  bank_data_o,
  input  logic                           bank_gnt_i,
  input  logic                           bank_r_valid_i,
  input  logic [DW-1:0]                  bank_r_data_i
);

  import hci_split_pkg::*;

  localparam int unsigned BW    = DW/8;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH+1);

  typedef struct packed {
    logic [ADDR_W-1:0] add;
    logic              wen;
    logic [BW-1:0]     be;
    logic [DW-1:0]     data;
  } req_entry_t;

  typedef struct packed {
    logic [DW-1:0] data;
  } rsp_entry_t;

  req_entry_t       req_in, req_head;
  rsp_entry_t       rsp_in, rsp_head;
  logic             req_full, req_empty, rsp_empty;
  logic [CNT_W-1:0] rsp_free;
  logic [CNT_W-1:0] outst_q;  // issued to bank, not yet answered
  logic             bank_fire;

  assign req_in = '{add: add_i, wen: wen_i, be: be_i, data: data_i};
  assign gnt_o  = ~req_full;

  hci_fifo_buf #(
    .DEPTH ( FIFO_DEPTH  ),
    .T     ( req_entry_t )
  ) i_req_fifo (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .push_i  ( req_i     ),
    .data_i  ( req_in    ),
    .pop_i   ( bank_fire ),
    .data_o  ( req_head  ),
    .full_o  ( req_full  ),
    .empty_o ( req_empty ),
    .free_o  (           )
  );

  // issue only while a response slot is guaranteed
  assign bank_req_o  = ~req_empty & (outst_q < rsp_free);
  assign bank_add_o  = req_head.add;
  assign bank_wen_o  = req_head.wen;
  assign bank_be_o   = req_head.be;
  assign bank_data_o = req_head.data;
  assign bank_fire   = bank_req_o & bank_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
    end else if (bank_fire && !bank_r_valid_i) begin
      outst_q <= outst_q + 1'b1;
    end else if (bank_r_valid_i && !bank_fire) begin
      outst_q <= outst_q - 1'b1;
    end
  end

  assign rsp_in = '{data: bank_r_data_i};

  hci_fifo_buf #(
    .DEPTH ( FIFO_DEPTH  ),
    .T     ( rsp_entry_t )
  ) i_rsp_fifo (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .push_i  ( bank_r_valid_i ),
    .data_i  ( rsp_in         ),
    .pop_i   ( pop_i          ),
    .data_o  ( rsp_head       ),
    .full_o  (                ),
    .empty_o ( rsp_empty      ),
    .free_o  ( rsp_free       )
  );

  assign r_valid_o = ~rsp_empty;
  assign r_data_o  = rsp_head.data;

endmodule

//--- verilog/hci_fifo_buf.sv
//==========================================================================
// Generic synchronous FIFO. The entry type is a type parameter, so one
// module holds both request entries and response entries. Pushes to a
// full FIFO and pops from an empty FIFO are ignored.
//==========================================================================
`timescale 1ns/1ps

module hci_fifo_buf #(
  parameter int unsigned DEPTH = 4,
  parameter type         T     = logic
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push_i,
  input  T                             data_i,
  input  logic                         pop_i,
  output T                             data_o,
  output logic                         full_o,
  output logic                         empty_o,
  output logic [$clog2(DEPTH+1)-1:0]   free_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH+1);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push, do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // storage, no reset on the payload
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        // explicit wrap, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];        // head of queue
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign free_o  = CNT_W'(DEPTH) - cnt_q;

endmodule

//--- verilog/hci_split_pkg.sv
//==========================================================================
// Shared sizes for the wide-to-narrow TCDM split.
// The RTL and the testbench import these. The top level takes its
// parameter defaults from here, and the derived widths stay local.
//==========================================================================

package hci_split_pkg;

  // byte address width on every port
  localparam int unsigned ADDR_W = 32;

  // defaults for the top-level parameters
  localparam int unsigned WIDE_DW_DEF    = 64;  // wide data width in bits
  localparam int unsigned NB_CHAN_DEF    = 2;   // narrow channels, one bank each
  localparam int unsigned FIFO_DEPTH_DEF = 4;   // entries per request and response FIFO
  localparam int unsigned BANK_WORDS_DEF = 256; // narrow words per bank

endpackage
